// ==== source/gpu_cfg_pkg.sv ====
package gpu_cfg_pkg;

    // Software visible CSR word
    typedef logic [31:0] csr_word_t;

    // Word select within one thread record
    typedef logic [1:0] csr_idx_t;

    localparam int RASTER_CSR_COUNT = 4;

    // Record word layout
    localparam csr_idx_t CSR_POS_MASK = 2'd0;
    localparam csr_idx_t CSR_BCOORD0  = 2'd1;

    // APB address, byte addressed
    typedef logic [15:0] apb_addr_t;

    // Field positions in the APB address map
    // Thread field sits right above the CSR index, warp id above the thread
    localparam int APB_CSR_LSB    = 2;
    localparam int APB_THREAD_LSB = APB_CSR_LSB + $bits(csr_idx_t);

endpackage

// ==== source/raster_pkg.sv ====
package raster_pkg;

    import gpu_cfg_pkg::*;

    // Quad coordinate
    typedef logic [13:0] pos_t;

    // Coverage of the four pixels in a quad
    typedef logic [3:0] quad_mask_t;

    typedef logic [31:0] bcoord_t;

    localparam int NUM_BCOORDS = 3;

    // One stamp from the rasterizer
    typedef struct packed {
        pos_t                          pos_x;
        pos_t                          pos_y;
        quad_mask_t                    mask;
        bcoord_t [NUM_BCOORDS-1:0]     bcoords;
    } raster_stamp_t;

    // Stored record, word 0 is {pos_y, pos_x, mask}, words 1 to 3 the bcoords
    typedef csr_word_t [RASTER_CSR_COUNT-1:0] raster_csrs_t;

endpackage

// ==== source/stamp_write_if.sv ====
interface stamp_write_if import raster_pkg::*; #(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS   = 4
) ();

    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;

    // One-cycle strobe, the store takes every one
    logic                            enable;
    logic [WID_W-1:0]                wid;
    logic [NUM_THREADS-1:0]          tmask;
    raster_stamp_t [NUM_THREADS-1:0] data;

    modport master (
        output enable,
        output wid,
        output tmask,
        output data
    );

    modport slave (
        input enable,
        input wid,
        input tmask,
        input data
    );

endinterface

// ==== source/csr_read_if.sv ====
interface csr_read_if import gpu_cfg_pkg::*; #(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS   = 4
) ();

    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;

    logic                        read_enable;
    logic [WID_W-1:0]            read_wid;
    csr_idx_t                    read_addr;
    // All threads of the warp at once
    csr_word_t [NUM_THREADS-1:0] read_data;

    modport master (
        output read_enable,
        output read_wid,
        output read_addr,
        input  read_data
    );

    modport slave (
        input  read_enable,
        input  read_wid,
        input  read_addr,
        output read_data
    );

endinterface

// ==== source/stamp_ram.sv ====
module stamp_ram #(
    parameter int DATAW = 128,
    parameter int SIZE  = 4,
    localparam int ADDRW = (SIZE > 1) ? $clog2(SIZE) : 1
) (
    input  logic             clk,
    input  logic             write,
    input  logic [ADDRW-1:0] waddr,
    input  logic [DATAW-1:0] wdata,
    input  logic [ADDRW-1:0] raddr,
    output logic [DATAW-1:0] rdata
);

    logic [DATAW-1:0] mem [SIZE];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
    end

    // LUT RAM style, read is combinational
    assign rdata = mem[raddr];

    // Non power of two depth leaves holes in the address space
    a_waddr_in_range: assert property (
        @(posedge clk) write |-> (int'(waddr) < SIZE)
    ) else $error("stamp_ram: write address %0d beyond depth %0d", waddr, SIZE);

endmodule

// ==== source/raster_csr.sv ====
module raster_csr
    import gpu_cfg_pkg::*;
    import raster_pkg::*;
#(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS   = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    stamp_write_if.slave     stamp_wr,
    csr_read_if.slave        csr_rd
);

    raster_csrs_t           lane_wdata [NUM_THREADS];
    raster_csrs_t           lane_rdata [NUM_THREADS];
    logic [NUM_THREADS-1:0] lane_write;

    // Pack each stamp into its record layout
    always_comb begin
        for (int i = 0; i < NUM_THREADS; i++) begin
            lane_wdata[i][CSR_POS_MASK] = {
                stamp_wr.data[i].pos_y,
                stamp_wr.data[i].pos_x,
                stamp_wr.data[i].mask
            };
            for (int j = 0; j < NUM_BCOORDS; j++) begin
                lane_wdata[i][int'(CSR_BCOORD0) + j] = stamp_wr.data[i].bcoords[j];
            end
        end
    end

    // One RAM per thread, indexed by warp id
    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_lane
        assign lane_write[i] = stamp_wr.enable && stamp_wr.tmask[i];

        stamp_ram #(
            .DATAW ($bits(raster_csrs_t)),
            .SIZE  (NUM_WARPS)
        ) u_store (
            .clk   (clk),
            .write (lane_write[i]),
            .waddr (stamp_wr.wid),
            .wdata (lane_wdata[i]),
            .raddr (csr_rd.read_wid),
            .rdata (lane_rdata[i])
        );

        assign csr_rd.read_data[i] = csr_rd.read_enable
                                   ? lane_rdata[i][csr_rd.read_addr]
                                   : '0;
    end

    // Asynchronous read needs a known address
    a_read_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        csr_rd.read_enable |-> !$isunknown({csr_rd.read_wid, csr_rd.read_addr})
    ) else $error("raster_csr: unknown read address, warp %b csr %b",
                  csr_rd.read_wid, csr_rd.read_addr);

endmodule

// ==== source/stamp_packer.sv ====
module stamp_packer
    import raster_pkg::*;
#(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS   = 4,
    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WID_W-1:0] in_wid,
    input  raster_stamp_t    in_stamp,
    input  logic             in_last,
    stamp_write_if.master    stamp_wr
);

    localparam int CNT_W = $clog2(NUM_THREADS + 1);

    typedef enum logic {
        FILL,
        COMMIT
    } pack_state_t;

    pack_state_t            state;
    logic [CNT_W-1:0]       lane_cnt;
    logic [WID_W-1:0]       group_wid;
    raster_stamp_t          lane_data [NUM_THREADS];
    logic [NUM_THREADS-1:0] fill_mask;
    logic                   accept;
    logic                   group_done;

    assign in_ready   = (state == FILL);
    assign accept     = in_valid && in_ready;
    assign group_done = in_last || (lane_cnt == CNT_W'(NUM_THREADS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= FILL;
            lane_cnt <= '0;
        end else begin
            case (state)
                FILL: begin
                    if (accept) begin
                        lane_cnt <= lane_cnt + 1'b1;
                        if (group_done) begin
                            state <= COMMIT;
                        end
                    end
                end
                COMMIT: begin
                    state    <= FILL;
                    lane_cnt <= '0;
                end
                default: state <= FILL;
            endcase
        end
    end

    // Lane payload, the warp id comes from the first stamp of the group
    always_ff @(posedge clk) begin
        if (accept && lane_cnt == '0) begin
            group_wid <= in_wid;
        end
        for (int i = 0; i < NUM_THREADS; i++) begin
            if (accept && lane_cnt == CNT_W'(i)) begin
                lane_data[i] <= in_stamp;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_THREADS; i++) begin
            fill_mask[i] = (lane_cnt > CNT_W'(i));
        end
    end

    assign stamp_wr.enable = (state == COMMIT);
    assign stamp_wr.wid    = group_wid;
    assign stamp_wr.tmask  = fill_mask;

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_data
        assign stamp_wr.data[i] = lane_data[i];
    end

    // A group belongs to one warp
    a_wid_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (accept && lane_cnt != '0) |-> (in_wid == group_wid)
    ) else $error("stamp_packer: warp id changed from %0d to %0d inside a group",
                  group_wid, in_wid);

endmodule

// ==== source/apb_csr_bridge.sv ====
module apb_csr_bridge
    import gpu_cfg_pkg::*;
#(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS   = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  csr_word_t pwdata,
    output csr_word_t prdata,
    output logic      pready,
    output logic      pslverr,
    csr_read_if.master csr_rd
);

    localparam int TID_W    = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1;
    localparam int WID_W    = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;
    localparam int WARP_LSB = APB_THREAD_LSB + TID_W;

    csr_idx_t         addr_csr;
    logic [TID_W-1:0] addr_tid;
    apb_addr_t        addr_warp;
    logic             range_err;
    logic             xfer_err;
    logic             setup;

    // Address decode
    assign addr_csr  = paddr[APB_CSR_LSB +: $bits(csr_idx_t)];
    assign addr_tid  = paddr[APB_THREAD_LSB +: TID_W];
    assign addr_warp = paddr >> WARP_LSB;

    assign range_err = (int'(addr_warp) >= NUM_WARPS) || (int'(addr_tid) >= NUM_THREADS);
    // Writes are not supported
    assign xfer_err  = pwrite || range_err;
    assign setup     = psel && !penable;

    // Held through setup and access
    assign csr_rd.read_enable = psel && !xfer_err;
    assign csr_rd.read_wid    = addr_warp[WID_W-1:0];
    assign csr_rd.read_addr   = addr_csr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            // No wait states, access always follows setup
            pready  <= setup;
            pslverr <= setup && xfer_err;
        end
    end

    always_ff @(posedge clk) begin
        if (setup) begin
            prdata <= xfer_err ? '0 : csr_rd.read_data[addr_tid];
        end
    end

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (!rst_n)
        penable |-> psel
    ) else $error("apb_csr_bridge: penable high without psel");

    // Write data is dropped, but a master must still drive it
    a_pwdata_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (psel && pwrite) |-> !$isunknown(pwdata)
    ) else $error("apb_csr_bridge: unknown pwdata on write to %h", paddr);

endmodule

// ==== source/raster_csr_unit.sv ====
module raster_csr_unit
    import gpu_cfg_pkg::*;
    import raster_pkg::*;
#(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS   = 4,
    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic             clk,
    input  logic             rst_n,

    // Stamp stream from the rasterizer
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WID_W-1:0] in_wid,
    input  raster_stamp_t    in_stamp,
    input  logic             in_last,

    // APB slave
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  apb_addr_t        paddr,
    input  csr_word_t        pwdata,
    output csr_word_t        prdata,
    output logic             pready,
    output logic             pslverr
);

    stamp_write_if #(
        .NUM_THREADS (NUM_THREADS),
        .NUM_WARPS   (NUM_WARPS)
    ) stamp_wr ();

    csr_read_if #(
        .NUM_THREADS (NUM_THREADS),
        .NUM_WARPS   (NUM_WARPS)
    ) csr_rd ();

    stamp_packer #(
        .NUM_THREADS (NUM_THREADS),
        .NUM_WARPS   (NUM_WARPS)
    ) u_packer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_wid   (in_wid),
        .in_stamp (in_stamp),
        .in_last  (in_last),
        .stamp_wr (stamp_wr.master)
    );

    raster_csr #(
        .NUM_THREADS (NUM_THREADS),
        .NUM_WARPS   (NUM_WARPS)
    ) u_csr (
        .clk      (clk),
        .rst_n    (rst_n),
        .stamp_wr (stamp_wr.slave),
        .csr_rd   (csr_rd.slave)
    );

    apb_csr_bridge #(
        .NUM_THREADS (NUM_THREADS),
        .NUM_WARPS   (NUM_WARPS)
    ) u_apb (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .csr_rd  (csr_rd.master)
    );

endmodule

// ==== verif/raster_csr_unit_tb.sv ====
module raster_csr_unit_tb
    import gpu_cfg_pkg::*;
    import raster_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLES_PER_CMD = 40;
    // Address map at the default size of four threads and four warps
    localparam int THREAD_LSB = 4;
    localparam int WARP_LSB   = 6;

    logic          clk;
    logic          rst_n    = 1'b0;
    logic          in_valid = 1'b0;
    logic          in_ready;
    logic [1:0]    in_wid   = '0;
    raster_stamp_t in_stamp = '0;
    logic          in_last  = 1'b0;
    logic          psel     = 1'b0;
    logic          penable  = 1'b0;
    logic          pwrite   = 1'b0;
    apb_addr_t     paddr    = '0;
    csr_word_t     pwdata   = '0;
    csr_word_t     prdata;
    logic          pready;
    logic          pslverr;

    string         cmd_q [$];
    string         cur_test = "reset_values";
    logic [31:0]   arg [8];
    int            n_cmds;
    int            n_tests;
    int            n_checks;
    int            n_errors;
    int            test_errors;

    raster_csr_unit dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog sized by the number of commands
    initial begin
        wait (n_cmds > 0);
        #((n_cmds * CYCLES_PER_CMD + 10) * 8);
        $display("Timeout: %0d commands did not finish in %0d cycles each", n_cmds,
                 CYCLES_PER_CMD);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        n_checks++;
        assert (act === exp) else begin
            test_errors++;
            $display("** Error: %s %s expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    // Setup then access, entered 1 ns after a rising edge
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input csr_word_t wdata,
                            output csr_word_t rdata, output logic err);
        // A closed group lands at the end of its commit cycle
        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        check_value("pready in setup", 32'h0, 32'(pready));
        @(posedge clk);
        #1;
        penable = 1'b1;
        check_value("pready in access", 32'h1, 32'(pready));
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic push_stamp();
        in_valid = 1'b1;
        in_wid   = arg[0][1:0];
        // pos_x, pos_y, mask, then bcoord 2 down to 0
        in_stamp = {arg[1][13:0], arg[2][13:0], arg[3][3:0], arg[6], arg[5], arg[4]};
        in_last  = arg[7][0];
        // Hold the stamp while the packer commits
        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    // All four CSRs of one thread of one warp
    task automatic read_record();
        apb_addr_t addr;
        csr_word_t rdata;
        logic      err;
        for (int k = 0; k < RASTER_CSR_COUNT; k++) begin
            addr = apb_addr_t'((arg[0] << WARP_LSB) | (arg[1] << THREAD_LSB) | (k << 2));
            apb_xfer(1'b0, addr, '0, rdata, err);
            check_value($sformatf("w%0d t%0d csr%0d", arg[0], arg[1], k), arg[2 + k], rdata);
            check_value($sformatf("w%0d t%0d pslverr", arg[0], arg[1]), 32'h0, 32'(err));
        end
    endtask

    task automatic end_test();
        $display("test %s: %s, %0d errors", cur_test,
                 (test_errors == 0) ? "ok" : "failed", test_errors);
        n_tests++;
        n_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic run_cmd(input string line);
        string     name;
        string     cmd;
        int        n;
        csr_word_t rdata;
        logic      err;
        n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h", name, cmd,
                    arg[0], arg[1], arg[2], arg[3], arg[4], arg[5], arg[6], arg[7]);
        if (name != cur_test) begin
            end_test();
            cur_test = name;
        end
        case (cmd)
            "push": push_stamp();
            "rec":  read_record();
            "apb": begin
                apb_xfer(arg[0][0], arg[1][15:0], arg[2], rdata, err);
                check_value("prdata", arg[3], rdata);
                check_value("pslverr", arg[4], 32'(err));
            end
            default: begin
                test_errors++;
                $display("%s: unknown command %s in a line of %0d fields", cur_test, cmd, n);
            end
        endcase
    endtask

    initial begin
        int    fd;
        string line;
        fd = $fopen("verif/raster_csr_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verif/raster_csr_tests.txt");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            while ($fgets(line, fd) > 0) begin
                // Skip comment and blank lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    cmd_q.push_back(line);
                end
            end
            $fclose(fd);
            n_cmds = cmd_q.size();
            repeat (3) @(posedge clk);
            #1;
            rst_n = 1'b1;
            check_value("pready after reset", 32'h0, 32'(pready));
            check_value("pslverr after reset", 32'h0, 32'(pslverr));
            check_value("in_ready after reset", 32'h1, 32'(in_ready));
            foreach (cmd_q[i]) begin
                run_cmd(cmd_q[i]);
            end
            end_test();
            $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
            if (n_errors == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== verif/raster_csr_tests.txt ====
# test cmd fields in hex: push wid pos_x pos_y mask bc0 bc1 bc2 last | apb write addr wdata data err
# rec wid thread csr0 csr1 csr2 csr3 reads the four CSRs of one thread and compares each
full_group push 1 0001 0002 f 11110000 11110001 11110002 0
full_group push 1 0010 0020 3 22220000 22220001 22220002 0
full_group push 1 0abc 1def 5 33330000 33330001 33330002 0
full_group push 1 3fff 3fff a 44440000 44440001 44440002 0
full_group rec 1 0 0008001f 11110000 11110001 11110002
full_group rec 1 1 00800103 22220000 22220001 22220002
full_group rec 1 2 77bcabc5 33330000 33330001 33330002
full_group rec 1 3 fffffffa 44440000 44440001 44440002
partial_group push 2 0001 0001 1 a0000000 a0000001 a0000002 0
partial_group push 2 0002 0002 2 a1000000 a1000001 a1000002 0
partial_group push 2 0003 0004 c a2000000 a2000001 a2000002 0
partial_group push 2 0004 0004 4 a3000000 a3000001 a3000002 0
partial_group push 2 0100 0200 1 b0000000 b0000001 b0000002 0
partial_group push 2 0101 0201 2 b1000000 b1000001 b1000002 1
partial_group rec 2 0 08001001 b0000000 b0000001 b0000002
partial_group rec 2 1 08041012 b1000000 b1000001 b1000002
partial_group rec 2 2 0010003c a2000000 a2000001 a2000002
partial_group rec 2 3 00100044 a3000000 a3000001 a3000002
isolation push 3 0123 0456 9 c0000000 c0000001 c0000002 1
isolation push 0 0005 0006 7 d0000000 d0000001 d0000002 1
isolation rec 3 0 11581239 c0000000 c0000001 c0000002
backpressure push 0 0011 0022 e e0000000 e0000001 e0000002 1
backpressure push 0 0033 0044 d e1000000 e1000001 e1000002 0
backpressure push 0 0007 0008 6 e2000000 e2000001 e2000002 1
backpressure rec 0 0 0110033d e1000000 e1000001 e1000002
backpressure rec 0 1 00200076 e2000000 e2000001 e2000002
apb_errors apb 1 0040 deadbeef 00000000 1
apb_errors apb 0 0100 00000000 00000000 1
apb_errors rec 1 0 0008001f 11110000 11110001 11110002

// ==== vlog.f ====
source/gpu_cfg_pkg.sv
source/raster_pkg.sv
source/stamp_write_if.sv
source/csr_read_if.sv
source/stamp_ram.sv
source/raster_csr.sv
source/stamp_packer.sv
source/apb_csr_bridge.sv
source/raster_csr_unit.sv
verif/raster_csr_unit_tb.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := raster_csr_unit_tb
FILELIST := vlog.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check the log in $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
